// ==== rtl/link_test_pkg.sv ====
`default_nettype none

package link_test_pkg;

	//////////////////////////////
	// basic widths
	typedef logic [31:0] word_t;	// bus and stream word
	typedef logic [15:0] addr_t;	// register address, top bits already consumed
	typedef logic [3:0]  keep_t;	// byte keep

	//////////////////////////////
	// link side bundles
	typedef struct packed {
		word_t data;
		logic  valid;
		keep_t keep;
		logic  last;
	} tx_stream_t;

	typedef struct packed {
		word_t data;
		logic  valid;
		keep_t keep;
		logic  last;
	} rx_stream_t;

	typedef struct packed {
		logic hard_err;
		logic soft_err;
		logic frame_err;
		logic lane_up;
		logic channel_up;
	} link_status_t;

	// status snapshot, 32 bits, msb first
	typedef struct packed {
		logic [19:0]  zero;		// always 0
		logic         tx_ready;
		logic         rx_valid;
		logic         rx_last;
		keep_t        rx_keep;
		link_status_t link;
	} stat_word_t;

	//////////////////////////////
	// host programmed registers
	typedef struct packed {
		word_t word1;
		word_t word2;
		word_t word3;
	} frame_regs_t;

	typedef struct packed {
		logic [1:0]        enable;	// bit 0 is channel 1
		logic              fsm_reset;	// soft clear for senders and timers
		frame_regs_t [1:0] frame;	// [0] channel 1, [1] channel 2
	} ctrl_regs_t;

	//////////////////////////////
	// register map
	localparam addr_t ADDR_EN        = 16'h0020;
	localparam addr_t ADDR_FSM_RESET = 16'h0030;
	localparam addr_t ADDR_CH1_BASE  = 16'h0021;	// +0..2 frame, +3..5 rx data, +6..8 stat
	localparam addr_t ADDR_CH2_BASE  = 16'h0031;
	localparam addr_t ADDR_LAT_1TO2  = 16'h0013;
	localparam addr_t ADDR_LAT_2TO1  = 16'h0014;

	localparam int FRAME_WORDS = 3;	// words per test frame
	localparam int HIST_DEPTH  = 3;	// captured words per channel

endpackage

`default_nettype wire

// ==== rtl/io_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_reg_file (
	input  logic                      io_clk,
	input  logic                      rst_n,
	input  logic                      io_sel,
	input  link_test_pkg::addr_t      io_addr,
	input  logic                      io_wr_en,
	input  link_test_pkg::word_t      io_wr_data,
	output link_test_pkg::ctrl_regs_t ctrl
);

	// frame word base per channel
	localparam link_test_pkg::addr_t CH_BASE [2] = '{
		link_test_pkg::ADDR_CH1_BASE,
		link_test_pkg::ADDR_CH2_BASE
	};

	logic             wr;		// qualified write strobe
	logic             wr_en_sel;
	logic             wr_rst_sel;
	logic [1:0][2:0]  wr_frame;	// [channel][word]

	//////////////////////////////
	// address decode
	assign wr         = io_sel & io_wr_en;
	assign wr_en_sel  = wr && (io_addr == link_test_pkg::ADDR_EN);
	assign wr_rst_sel = wr && (io_addr == link_test_pkg::ADDR_FSM_RESET);

	for (genvar c = 0; c < 2; c++) begin : g_ch
		for (genvar k = 0; k < 3; k++) begin : g_word
			assign wr_frame[c][k] = wr &&
				(io_addr == CH_BASE[c] + link_test_pkg::addr_t'(k));	// base+0..2
		end
	end

	//////////////////////////////
	// register bank
	always_ff @(posedge io_clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;	// everything reads 0 after reset
		end else begin
			if (wr_en_sel)
				ctrl.enable <= io_wr_data[1:0];
			if (wr_rst_sel)
				ctrl.fsm_reset <= io_wr_data[0];	// held until host clears it
			for (int c = 0; c < 2; c++) begin
				if (wr_frame[c][0])
					ctrl.frame[c].word1 <= io_wr_data;
				if (wr_frame[c][1])
					ctrl.frame[c].word2 <= io_wr_data;
				if (wr_frame[c][2])
					ctrl.frame[c].word3 <= io_wr_data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/frame_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sender #(
	parameter int FRAME_WORDS = 3
) (
	input  logic                       io_clk,
	input  logic                       rst_n,
	input  logic                       en,
	input  logic                       fsm_reset,
	input  link_test_pkg::frame_regs_t frame,
	input  logic                       tx_ready,
	output link_test_pkg::tx_stream_t  tx
);

	localparam int IDX_W = $clog2(FRAME_WORDS + 1);

	typedef enum logic {S_IDLE, S_SEND} state_t;

	state_t               state;
	logic                 en_q, en_qq;	// enable edge detect
	logic [IDX_W-1:0]     idx;		// word on the stream now
	logic                 valid_q, last_q;
	link_test_pkg::word_t data_q;
	link_test_pkg::word_t words [3];
	logic                 rise, xfer, at_end;
	logic                 load_first, load_next;

	assign words[0] = frame.word1;
	assign words[1] = frame.word2;
	assign words[2] = frame.word3;

	assign rise       = en_q & ~en_qq;
	assign xfer       = valid_q & tx_ready;	// word accepted this edge
	assign at_end     = (idx == IDX_W'(FRAME_WORDS - 1));
	assign load_first = (state == S_IDLE) & rise & ~fsm_reset;
	assign load_next  = (state == S_SEND) & xfer & ~at_end & ~fsm_reset;

	//////////////////////////////
	// control FSM
	always_ff @(posedge io_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			en_q    <= 1'b0;
			en_qq   <= 1'b0;
			idx     <= '0;
			valid_q <= 1'b0;
		end else begin
			en_q  <= en;
			en_qq <= en_q;	// rise while soft reset is high gets dropped
			if (fsm_reset) begin
				state   <= S_IDLE;
				idx     <= '0;
				valid_q <= 1'b0;
			end else if (load_first) begin
				state   <= S_SEND;
				idx     <= '0;
				valid_q <= 1'b1;
			end else if (state == S_SEND && xfer) begin
				if (at_end) begin
					state   <= S_IDLE;	// frame done
					valid_q <= 1'b0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	// payload only moves on a load, so it holds under back-pressure
	always_ff @(posedge io_clk) begin
		if (load_first) begin
			data_q <= words[0];
			last_q <= (FRAME_WORDS == 1);
		end else if (load_next) begin
			data_q <= words[idx + 1'b1];
			last_q <= (idx + 1'b1 == IDX_W'(FRAME_WORDS - 1));
		end
	end

	assign tx = '{data: data_q, valid: valid_q, keep: '1, last: last_q};

	a_hold_on_stall: assert property (@(posedge io_clk) disable iff (!rst_n)
		valid_q && !tx_ready |=> $stable(data_q) && $stable(last_q));

endmodule

`default_nettype wire

// ==== rtl/rx_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_capture #(
	parameter type item_t = logic [31:0],
	parameter int  DEPTH  = 3
) (
	input  logic  io_clk,
	input  logic  rst_n,
	input  logic  shift,
	input  item_t item_in,
	output item_t hist [DEPTH]
);

	//////////////////////////////
	// shift history
	// hist[0] oldest, hist[DEPTH-1] newest

	always_ff @(posedge io_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				hist[i] <= '0;	// readback shows 0 until traffic
		end else if (shift) begin
			for (int i = 0; i < DEPTH - 1; i++)
				hist[i] <= hist[i + 1];	// age by one
			hist[DEPTH - 1] <= item_in;	// newest word
		end
	end

endmodule

`default_nettype wire

// ==== rtl/latency_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module latency_timer #(
	parameter int CNT_W = 32
) (
	input  logic             io_clk,
	input  logic             rst_n,
	input  logic             fsm_reset,
	input  logic             start,	// tx valid of the sending channel
	input  logic             stop,	// rx valid of the far channel
	output logic [CNT_W-1:0] count
);

	typedef enum logic [1:0] {T_IDLE, T_RUN, T_DONE} tstate_t;

	tstate_t state;
	logic    start_q;

	//////////////////////////////
	// one shot measurement
	always_ff @(posedge io_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= T_IDLE;
			start_q <= 1'b0;
			count   <= '0;
		end else begin
			start_q <= start;
			if (fsm_reset) begin
				state <= T_IDLE;	// rearm, result back to 0
				count <= '0;
			end else begin
				case (state)
					T_IDLE: if (start && !start_q) begin
						if (stop) begin
							state <= T_DONE;	// zero delay link
						end else begin
							state <= T_RUN;
							count <= CNT_W'(1);	// first edge after the rise
						end
					end
					T_RUN: if (stop) state <= T_DONE;
					else count <= count + 1'b1;
					default: ;	// done, result frozen
				endcase
			end
		end
	end

	a_frozen: assert property (@(posedge io_clk) disable iff (!rst_n)
		(state == T_DONE) && !fsm_reset |=> $stable(count));

endmodule

`default_nettype wire

// ==== rtl/readback_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module readback_mux #(
	parameter int CNT_W = 32
) (
	input  logic                       io_clk,
	input  logic                       rst_n,
	input  logic                       io_sel,
	input  logic                       io_sync,
	input  logic                       io_rd_en,
	input  link_test_pkg::addr_t       io_addr,
	input  link_test_pkg::ctrl_regs_t  ctrl,
	input  link_test_pkg::word_t       data_hist [2][link_test_pkg::HIST_DEPTH],
	input  link_test_pkg::stat_word_t  stat_hist [2][link_test_pkg::HIST_DEPTH],
	input  logic [CNT_W-1:0]           lat_1to2,
	input  logic [CNT_W-1:0]           lat_2to1,
	output link_test_pkg::word_t       io_rd_data,
	output logic                       io_rd_ack
);

	localparam link_test_pkg::addr_t CH_BASE [2] = '{
		link_test_pkg::ADDR_CH1_BASE,
		link_test_pkg::ADDR_CH2_BASE
	};

	logic [CNT_W-1:0]     lat_1to2_q, lat_2to1_q;	// extra stage on timer results
	logic                 rd_hit;			// address known
	link_test_pkg::word_t rd_val;

	//////////////////////////////
	// read decode
	always_comb begin
		rd_hit = 1'b1;
		rd_val = '0;
		case (io_addr)
			link_test_pkg::ADDR_EN:        rd_val = 32'(ctrl.enable);
			link_test_pkg::ADDR_FSM_RESET: rd_val = 32'(ctrl.fsm_reset);
			link_test_pkg::ADDR_LAT_1TO2:  rd_val = 32'(lat_1to2_q);
			link_test_pkg::ADDR_LAT_2TO1:  rd_val = 32'(lat_2to1_q);
			default:                       rd_hit = 1'b0;
		endcase
		for (int c = 0; c < 2; c++) begin
			if (io_addr == CH_BASE[c]) begin
				rd_hit = 1'b1;
				rd_val = ctrl.frame[c].word1;
			end
			if (io_addr == CH_BASE[c] + 16'd1) begin
				rd_hit = 1'b1;
				rd_val = ctrl.frame[c].word2;
			end
			if (io_addr == CH_BASE[c] + 16'd2) begin
				rd_hit = 1'b1;
				rd_val = ctrl.frame[c].word3;
			end
			for (int k = 0; k < link_test_pkg::HIST_DEPTH; k++) begin
				if (io_addr == CH_BASE[c] + 16'(3 + k)) begin
					rd_hit = 1'b1;
					rd_val = data_hist[c][k];	// rx data 1..3
				end
				if (io_addr == CH_BASE[c] + 16'(6 + k)) begin
					rd_hit = 1'b1;
					rd_val = stat_hist[c][k];	// status 1..3
				end
			end
		end
	end

	always_ff @(posedge io_clk or negedge rst_n) begin
		if (!rst_n) begin
			lat_1to2_q <= '0;
			lat_2to1_q <= '0;
			io_rd_data <= '0;
			io_rd_ack  <= 1'b0;
		end else begin
			lat_1to2_q <= lat_1to2;
			lat_2to1_q <= lat_2to1;
			io_rd_ack  <= io_sync & io_sel & io_rd_en;	// one pulse per started read
			if (io_sel && io_rd_en && rd_hit)
				io_rd_data <= rd_val;	// unknown address keeps old data
		end
	end

endmodule

`default_nettype wire

// ==== rtl/link_test_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_test_top #(
	parameter int CNT_W = 32
) (
	input  logic                        io_clk,
	input  logic                        rst_n,
	// host bus
	input  logic                        io_sel,
	input  logic                        io_sync,
	input  link_test_pkg::addr_t        io_addr,
	input  logic                        io_rd_en,
	input  logic                        io_wr_en,
	input  link_test_pkg::word_t        io_wr_data,
	output link_test_pkg::word_t        io_rd_data,
	output logic                        io_rd_ack,
	// link side, testbench plays the serial cores
	output link_test_pkg::tx_stream_t   tx1,
	output link_test_pkg::tx_stream_t   tx2,
	input  logic                        tx_ready1,
	input  logic                        tx_ready2,
	input  link_test_pkg::rx_stream_t   rx1,
	input  link_test_pkg::rx_stream_t   rx2,
	input  link_test_pkg::link_status_t stat1,
	input  link_test_pkg::link_status_t stat2
);

	localparam int DEPTH = link_test_pkg::HIST_DEPTH;

	link_test_pkg::ctrl_regs_t    ctrl;
	link_test_pkg::tx_stream_t    tx [2];
	logic                         tx_ready [2];
	link_test_pkg::rx_stream_t    rx [2];
	link_test_pkg::link_status_t  stat [2];
	link_test_pkg::stat_word_t    stat_in [2];	// snapshot taken per rx word
	link_test_pkg::word_t         data_hist [2][DEPTH];
	link_test_pkg::stat_word_t    stat_hist [2][DEPTH];
	logic [CNT_W-1:0]             lat_1to2, lat_2to1;

	// channel index 0 is channel 1
	assign tx1         = tx[0];
	assign tx2         = tx[1];
	assign tx_ready[0] = tx_ready1;
	assign tx_ready[1] = tx_ready2;
	assign rx[0]       = rx1;
	assign rx[1]       = rx2;
	assign stat[0]     = stat1;
	assign stat[1]     = stat2;

	io_reg_file u_regs (
		.io_clk, .rst_n, .io_sel, .io_addr, .io_wr_en, .io_wr_data,
		.ctrl   (ctrl)
	);

	//////////////////////////////
	// per channel tx and capture
	for (genvar c = 0; c < 2; c++) begin : g_chan
		assign stat_in[c] = '{zero: '0, tx_ready: tx_ready[c], rx_valid: rx[c].valid,
			rx_last: rx[c].last, rx_keep: rx[c].keep, link: stat[c]};

		frame_sender #(.FRAME_WORDS(link_test_pkg::FRAME_WORDS)) u_sender (
			.io_clk, .rst_n,
			.en        (ctrl.enable[c]),
			.fsm_reset (ctrl.fsm_reset),
			.frame     (ctrl.frame[c]),
			.tx_ready  (tx_ready[c]),
			.tx        (tx[c])
		);

		rx_capture #(.item_t(link_test_pkg::word_t), .DEPTH(DEPTH)) u_data_cap (
			.io_clk, .rst_n,
			.shift   (rx[c].valid),
			.item_in (rx[c].data),
			.hist    (data_hist[c])
		);

		rx_capture #(.item_t(link_test_pkg::stat_word_t), .DEPTH(DEPTH)) u_stat_cap (
			.io_clk, .rst_n,
			.shift   (rx[c].valid),
			.item_in (stat_in[c]),
			.hist    (stat_hist[c])
		);
	end

	//////////////////////////////
	// cross channel latency
	latency_timer #(.CNT_W(CNT_W)) u_lat_1to2 (
		.io_clk, .rst_n, .fsm_reset(ctrl.fsm_reset),
		.start (tx[0].valid), .stop(rx[1].valid), .count(lat_1to2)
	);

	latency_timer #(.CNT_W(CNT_W)) u_lat_2to1 (
		.io_clk, .rst_n, .fsm_reset(ctrl.fsm_reset),
		.start (tx[1].valid), .stop(rx[0].valid), .count(lat_2to1)
	);

	readback_mux #(.CNT_W(CNT_W)) u_rdbk (
		.io_clk, .rst_n, .io_sel, .io_sync, .io_rd_en, .io_addr,
		.ctrl, .data_hist, .stat_hist, .lat_1to2, .lat_2to1,
		.io_rd_data, .io_rd_ack
	);

endmodule

`default_nettype wire

// ==== bench/tb_link_test.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_link_test;

	localparam int    HALF_PERIOD = 2;	// 4 ns clock
	localparam int    RESET_CYC   = 16;
	localparam int    D           = 5;	// link delay in cycles
	localparam int    CYC_LINE    = 200;	// run budget per data line
	localparam int    ACK_WAIT    = 8;
	localparam int    SEED        = 32'h6b9e_cbc3;
	localparam string DATA_FILE   = "bench/link_test_testdata.txt";

	logic                        io_clk = 1'b0;
	logic                        rst_n;
	logic                        io_sel, io_sync, io_rd_en, io_wr_en;
	link_test_pkg::addr_t        io_addr;
	link_test_pkg::word_t        io_wr_data;
	link_test_pkg::word_t        io_rd_data;
	logic                        io_rd_ack;
	link_test_pkg::tx_stream_t   tx1, tx2;
	logic                        tx_ready1 = 1'b1;
	logic                        tx_ready2 = 1'b1;
	link_test_pkg::rx_stream_t   rx1 = '0;
	link_test_pkg::rx_stream_t   rx2 = '0;
	link_test_pkg::link_status_t stat1, stat2;

	// link model state, [0] newest transfer
	link_test_pkg::tx_stream_t [D:0] pipe12 = '0;
	link_test_pkg::tx_stream_t [D:0] pipe21 = '0;
	logic stall1 = 1'b0;
	logic stall2 = 1'b0;
	logic rnd_ready = 1'b1;	// ready pick while stalling

	// command list from the data file
	logic [7:0]  cmd_op [$];
	logic [31:0] cmd_a [$];
	logic [31:0] cmd_b [$];

	int cur_test    = 0;
	int test_errs   = 0;
	int n_pass      = 0;
	int n_fail      = 0;
	int cycles      = 0;
	int cycle_limit = CYC_LINE;

	always #HALF_PERIOD io_clk = ~io_clk;

	link_test_top #(.CNT_W(32)) i_dut (
		.io_clk, .rst_n, .io_sel, .io_sync, .io_addr, .io_rd_en, .io_wr_en, .io_wr_data,
		.io_rd_data, .io_rd_ack, .tx1, .tx2, .tx_ready1, .tx_ready2, .rx1, .rx2,
		.stat1, .stat2
	);

	//////////////////////////////
	// serial link stand-in
	always @(negedge io_clk) begin : link_model
		link_test_pkg::tx_stream_t w1, w2;
		tx_ready1 = stall1 ? rnd_ready : 1'b1;
		tx_ready2 = stall2 ? rnd_ready : 1'b1;
		w1 = (tx1.valid && tx_ready1) ? tx1 : '0;	// only words taken on the next edge
		w2 = (tx2.valid && tx_ready2) ? tx2 : '0;
		pipe12 = {pipe12[D-1:0], w1};
		pipe21 = {pipe21[D-1:0], w2};
		rx2 = link_test_pkg::rx_stream_t'(pipe12[D]);	// lands D edges after transfer
		rx1 = link_test_pkg::rx_stream_t'(pipe21[D]);
	end

	always @(posedge io_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic load_commands(output bit ok);
		int          fd, n;
		string       line;
		logic [7:0]  op;
		logic [31:0] a, b;
		fd = $fopen(DATA_FILE, "r");
		ok = (fd != 0);
		while (ok && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() >= 3 && line.getc(0) != "#") begin
				b = '0;
				n = $sscanf(line, "%c %h %h", op, a, b);
				if (n >= 2) begin
					cmd_op.push_back(op);
					cmd_a.push_back(a);
					cmd_b.push_back(b);
				end
			end
		end
		if (ok)
			$fclose(fd);
	endtask

	task automatic write_reg(input link_test_pkg::addr_t addr, input link_test_pkg::word_t data);
		io_sel     = 1'b1;
		io_wr_en   = 1'b1;
		io_addr    = addr;
		io_wr_data = data;
		@(negedge io_clk);
		io_sel   = 1'b0;
		io_wr_en = 1'b0;
	endtask

	// ack_at counts cycles from the request edge, 0 if never seen
	task automatic read_reg(input link_test_pkg::addr_t addr, output link_test_pkg::word_t data,
		output int ack_at, output bit ack_held);
		int waited;
		io_sel   = 1'b1;
		io_sync  = 1'b1;
		io_rd_en = 1'b1;
		io_addr  = addr;
		@(negedge io_clk);
		io_sel   = 1'b0;
		io_sync  = 1'b0;
		io_rd_en = 1'b0;
		waited   = 1;
		while (!io_rd_ack && waited < ACK_WAIT) begin
			@(negedge io_clk);
			waited++;
		end
		ack_at = io_rd_ack ? waited : 0;
		data   = io_rd_data;
		@(negedge io_clk);
		ack_held = io_rd_ack;	// should be a single pulse
	endtask

	task automatic stall_ready(input int chan, input int n);
		@(posedge io_clk);	// flags move away from the drive edge
		stall1 = (chan == 1);
		stall2 = (chan == 2);
		repeat (n) begin
			rnd_ready = (($urandom % 2) == 1);
			@(posedge io_clk);
		end
		stall1 = 1'b0;
		stall2 = 1'b0;
		@(negedge io_clk);
	endtask

	// senders stay quiet while the soft reset is set
	task automatic idle_cycles(input int n, input bit soft_rst);
		repeat (n) begin
			@(negedge io_clk);
			if (soft_rst && (tx1.valid || tx2.valid)) begin
				$display("** Error @ %0t: tx valid while soft reset is set", $time);
				test_errs++;
			end
		end
	endtask

	task automatic close_test();
		if (cur_test > 0 || test_errs > 0) begin
			if (test_errs == 0) begin
				n_pass++;
				$display("test %0d: ok", cur_test);
			end else begin
				n_fail++;
				$display("test %0d: %0d check(s) failed", cur_test, test_errs);
			end
		end
		test_errs = 0;
	endtask

	//////////////////////////////
	// command interpreter
	task automatic run_commands();
		link_test_pkg::word_t got;
		int                   ack_at;
		bit                   ack_held;
		bit                   soft_rst = 1'b0;	// last value written to the soft reset
		for (int i = 0; i < cmd_op.size(); i++) begin
			case (cmd_op[i])
				"T": begin
					close_test();
					cur_test = cmd_a[i];
				end
				"W": begin
					write_reg(cmd_a[i][15:0], cmd_b[i]);
					if (cmd_a[i][15:0] == link_test_pkg::ADDR_FSM_RESET)
						soft_rst = cmd_b[i][0];
				end
				"P": idle_cycles(cmd_a[i], soft_rst);
				"S": stall_ready(cmd_a[i], cmd_b[i]);
				"L": begin
					if (cmd_a[i] == 1)
						stat1 = link_test_pkg::link_status_t'(cmd_b[i][4:0]);
					else
						stat2 = link_test_pkg::link_status_t'(cmd_b[i][4:0]);
				end
				"R": begin
					read_reg(cmd_a[i][15:0], got, ack_at, ack_held);
					if (ack_at == 0) begin
						$display("read of %04h got no ack within %0d cycles",
							cmd_a[i][15:0], ACK_WAIT);
						test_errs++;
					end else if (ack_at != 1) begin
						$display("read of %04h acked after %0d cycles instead of 1",
							cmd_a[i][15:0], ack_at);
						test_errs++;
					end
					if (ack_held) begin
						$display("read of %04h held ack high for more than one cycle",
							cmd_a[i][15:0]);
						test_errs++;
					end
					if (got !== cmd_b[i]) begin
						$display("** Error @ %0t: read %04h returned %08h, expected %08h",
							$time, cmd_a[i][15:0], got, cmd_b[i]);
						test_errs++;
					end
				end
				default: begin
					$display("unknown command %c in data entry %0d", cmd_op[i], i);
					test_errs++;
				end
			endcase
		end
	endtask

	initial begin : main
		bit ok;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		io_sel     = 1'b0;
		io_sync    = 1'b0;
		io_rd_en   = 1'b0;
		io_wr_en   = 1'b0;
		io_addr    = '0;
		io_wr_data = '0;
		stat1      = '0;
		stat2      = '0;
		load_commands(ok);
		if (!ok) begin
			$display("could not open %s, no stimulus to run", DATA_FILE);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			cycle_limit = CYC_LINE * cmd_op.size();
			repeat (RESET_CYC) @(negedge io_clk);
			rst_n = 1'b1;
			@(negedge io_clk);
			run_commands();
			close_test();
			$display("summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
			if (n_fail == 0 && n_pass > 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/link_test_pkg.sv
rtl/io_reg_file.sv
rtl/frame_sender.sv
rtl/rx_capture.sv
rtl/latency_timer.sv
rtl/readback_mux.sv
rtl/link_test_top.sv
bench/tb_link_test.sv

// ==== Makefile ====
# Verilator build for the serial link test block
# run from the project root, the testbench opens its data file by relative path

VERILATOR ?= verilator
TOP       ?= tb_link_test
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# result is taken from the simulator output only
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/link_test_testdata.txt ====
# op a b, a and b in hex
# W addr data | R addr expected | S chan cycles | P cycles 0 | L chan status | T test 0
L 1 03
L 2 01
T 1 0
R 0021 00000000
R 0033 00000000
R 0024 00000000
R 0039 00000000
R 0013 00000000
R 0014 00000000
T 2 0
W 0021 a5a50001
W 0022 a5a50002
W 0023 a5a50003
W 0031 5a5a0011
W 0032 5a5a0012
W 0033 5a5a0013
R 0021 a5a50001
R 0022 a5a50002
R 0023 a5a50003
R 0031 5a5a0011
R 0032 5a5a0012
R 0033 5a5a0013
T 3 0
W 0020 00000001
P 14 0
R 0034 a5a50001
R 0035 a5a50002
R 0036 a5a50003
R 0037 00000de1
R 0038 00000de1
R 0039 00000fe1
T 4 0
R 0013 00000005
W 0020 00000002
P 14 0
R 0014 00000005
R 0026 5a5a0013
R 0029 00000fe3
T 5 0
W 0021 c0de0101
W 0022 c0de0102
W 0023 c0de0103
W 0020 00000001
S 1 30
P 14 0
R 0034 c0de0101
R 0035 c0de0102
R 0036 c0de0103
T 6 0
W 0030 00000001
W 0030 00000000
P 4 0
R 0013 00000000
R 0014 00000000
W 0030 00000001
W 0020 00000000
W 0020 00000001
P 4 0
W 0030 00000000
P 14 0
R 0030 00000000
R 0036 c0de0103
R 0013 00000000
